//--- Makefile
# Verilator simulation of the video subsystem
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module video_tb -f video.f -o video_sim
	./obj_dir/video_sim | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- source/host_pkg.sv
`default_nettype none

package host_pkg;

// CPU address map
localparam logic [7:0] TXT_BASE = 8'h00;
localparam logic [7:0] BCK_BASE = 8'h10;
localparam int         MAP_LEN  = 8;              // Entries per range
localparam int         MAP_AW   = $clog2(MAP_LEN);

typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
    logic       we;
} cpu_wr_t;

// PROM loader, one enable per table
typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
    logic       glyph_we;
    logic       pal_we;
} prom_wr_t;

endpackage

`default_nettype wire

//--- source/video.sv
`timescale 1ns/1ns
`default_nettype none

module video import video_pkg::*, host_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     pxl_cen,
    input  cpu_wr_t  cpu,       // Tile and cell writes
    input  prom_wr_t prom,      // Glyph and palette loading
    output rgb_t     rgb,
    output logic     HB,        // Horizontal blanking
    output logic     VB         // Vertical blanking
);

hv_t        hv;
layer_pix_t txt_pix;
layer_pix_t bck_pix;

video_timing u_timing (
    .clk        ( clk       ),
    .rst        ( rst       ),
    .pxl_cen    ( pxl_cen   ),
    .hv         ( hv        )
);

video_txt u_txt (
    .clk        ( clk       ),
    .rst        ( rst       ),
    .pxl_cen    ( pxl_cen   ),
    .cpu        ( cpu       ),
    .prom       ( prom      ),
    .hv         ( hv        ),
    .pix        ( txt_pix   )
);

video_bck u_bck (
    .clk        ( clk       ),
    .rst        ( rst       ),
    .pxl_cen    ( pxl_cen   ),
    .cpu        ( cpu       ),
    .hv         ( hv        ),
    .pix        ( bck_pix   )
);

// Three ticks from counters to rgb
video_colmix u_colmix (
    .clk        ( clk       ),
    .rst        ( rst       ),
    .pxl_cen    ( pxl_cen   ),
    .prom       ( prom      ),
    .txt        ( txt_pix   ),
    .bck        ( bck_pix   ),
    .rgb        ( rgb       ),
    .hb         ( HB        ),
    .vb         ( VB        )
);

endmodule

`default_nettype wire

//--- source/video_bck.sv
`timescale 1ns/1ns
`default_nettype none

module video_bck import video_pkg::*, host_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    input  cpu_wr_t    cpu,
    input  hv_t        hv,
    output layer_pix_t pix
);

logic [TILE_IDX_W-1:0] cell_idx;
logic                  cell_we;
bck_cell_t             cell_q;       // Stage 1
logic [3:0]            color_s2;     // Held one tick to match the text lag
logic [PIX_LAG-1:0]    hb_d;
logic [PIX_LAG-1:0]    vb_d;

assign cell_we  = cpu.we && cpu.addr[7:MAP_AW] == BCK_BASE[7:MAP_AW];
assign cell_idx = {hv.v[TILE_SZ_W +: TILE_ROW_W], hv.h[TILE_SZ_W +: TILE_COL_W]};

// Colour cells, one per tile position
video_ram #(
    .elem_t ( bck_cell_t ),
    .DEPTH  ( TILE_CNT   )
) u_cells (
    .clk    ( clk                       ),
    .we     ( cell_we                   ),
    .waddr  ( cpu.addr[MAP_AW-1:0]      ),
    .wdata  ( bck_cell_t'(cpu.data[3:0]) ),
    .ren    ( pxl_cen                   ),
    .raddr  ( cell_idx                  ),
    .rdata  ( cell_q                    )
);

always_ff @(posedge clk) begin
    if (pxl_cen) begin
        color_s2 <= cell_q.color;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        hb_d <= '0;
        vb_d <= '0;
    end else if (pxl_cen) begin
        hb_d <= PIX_LAG'({hb_d, hv.hb});
        vb_d <= PIX_LAG'({vb_d, hv.vb});
    end
end

always_comb begin
    pix.color = color_s2;
    pix.valid = ~(hb_d[PIX_LAG-1] | vb_d[PIX_LAG-1]);   // Solid layer
    pix.hb    = hb_d[PIX_LAG-1];
    pix.vb    = vb_d[PIX_LAG-1];
end

endmodule

`default_nettype wire

//--- source/video_colmix.sv
`timescale 1ns/1ns
`default_nettype none

module video_colmix import video_pkg::*, host_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    input  prom_wr_t   prom,
    input  layer_pix_t txt,
    input  layer_pix_t bck,
    output rgb_t       rgb,
    output logic       hb,
    output logic       vb
);

logic [PAL_AW-1:0] pal_addr;
logic [7:0]        pal_q;
logic [PIX_LAG:0]  fill;         // Pipeline filled since reset
logic              show;

// Text wins over background, text colours live in the upper half
assign pal_addr = txt.valid ? {1'b1, txt.color} : {1'b0, bck.color};

video_ram #(
    .elem_t ( logic [7:0] ),
    .DEPTH  ( PAL_DEPTH   )
) u_pal (
    .clk    ( clk                    ),
    .we     ( prom.pal_we            ),
    .waddr  ( prom.addr[PAL_AW-1:0]  ),
    .wdata  ( prom.data              ),
    .ren    ( pxl_cen                ),
    .raddr  ( pal_addr               ),
    .rdata  ( pal_q                  )
);

// Flags delayed together with the palette read
always_ff @(posedge clk) begin
    if (rst) begin
        hb   <= 1'b0;
        vb   <= 1'b0;
        fill <= '0;
    end else if (pxl_cen) begin
        hb   <= txt.hb;
        vb   <= txt.vb;
        fill <= (PIX_LAG + 1)'({fill, 1'b1});
    end
end

assign show = fill[PIX_LAG] & ~hb & ~vb;

always_comb begin
    rgb = '0;
    if (show) begin
        rgb.red   = pal_q[7:5];
        rgb.green = pal_q[4:2];
        rgb.blue  = {pal_q[1:0], 1'b0};   // 2-bit blue in the PROM
    end
end

endmodule

`default_nettype wire

//--- source/video_pkg.sv
`default_nettype none

package video_pkg;

// Raster geometry, cut down for short runs
localparam int H_TOTAL  = 48;
localparam int H_ACTIVE = 32;
localparam int V_TOTAL  = 24;
localparam int V_ACTIVE = 16;
localparam int H_W      = $clog2(H_TOTAL);
localparam int V_W      = $clog2(V_TOTAL);

// Screen in 8x8 tiles
localparam int TILE_COLS  = 4;
localparam int TILE_ROWS  = 2;
localparam int TILE_CNT   = TILE_COLS * TILE_ROWS;
localparam int TILE_SZ_W  = 3;                    // log2 of tile size
localparam int TILE_COL_W = $clog2(TILE_COLS);
localparam int TILE_ROW_W = $clog2(TILE_ROWS);
localparam int TILE_IDX_W = TILE_COL_W + TILE_ROW_W;

localparam int GLYPH_DEPTH = 128;                 // 16 glyphs of 8 rows
localparam int PAL_DEPTH   = 32;
localparam int PAL_AW      = $clog2(PAL_DEPTH);
localparam int PIX_LAG     = 2;                   // Ticks from hv_t to layer pixel

typedef struct packed {
    logic [H_W-1:0] h;
    logic [V_W-1:0] v;
    logic           hb;
    logic           vb;
} hv_t;

typedef struct packed {
    logic [3:0] code;    // Glyph number
    logic [3:0] color;   // Palette group
} txt_tile_t;

typedef struct packed {
    logic [3:0] color;
} bck_cell_t;

// One layer's pixel, blanking flags travel along with it
typedef struct packed {
    logic [3:0] color;
    logic       valid;
    logic       hb;
    logic       vb;
} layer_pix_t;

typedef struct packed {
    logic [2:0] red;
    logic [2:0] green;
    logic [2:0] blue;    // LSB stays zero
} rgb_t;

endpackage

`default_nettype wire

//--- source/video_ram.sv
`timescale 1ns/1ns
`default_nettype none

module video_ram #(
    parameter type elem_t = logic [7:0],
    parameter int  DEPTH  = 8
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  elem_t                    wdata,
    input  logic                     ren,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output elem_t                    rdata
);

elem_t mem [DEPTH];

always_ff @(posedge clk) begin
    if (we) begin
        mem[waddr] <= wdata;
    end
end

// Read port, old data on a same-address write
always_ff @(posedge clk) begin
    if (ren) begin
        rdata <= mem[raddr];
    end
end

endmodule

`default_nettype wire

//--- source/video_timing.sv
`timescale 1ns/1ns
`default_nettype none

module video_timing import video_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic pxl_cen,
    output hv_t  hv
);

logic [H_W-1:0] h_nxt;
logic [V_W-1:0] v_nxt;
logic           h_wrap;
logic           v_wrap;

assign h_wrap = hv.h == H_W'(H_TOTAL - 1);
assign v_wrap = hv.v == V_W'(V_TOTAL - 1);

always_comb begin
    h_nxt = hv.h + 1'b1;
    v_nxt = hv.v;
    if (h_wrap) begin
        h_nxt = '0;
        // Line done, step the frame counter
        v_nxt = v_wrap ? '0 : hv.v + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        hv.h <= '0;
        hv.v <= '0;
    end else if (pxl_cen) begin
        hv.h <= h_nxt;
        hv.v <= v_nxt;
    end
end

// Flags taken from the next count so they line up with the counters
always_ff @(posedge clk) begin
    if (rst) begin
        hv.hb <= 1'b0;
        hv.vb <= 1'b0;
    end else if (pxl_cen) begin
        hv.hb <= h_nxt >= H_W'(H_ACTIVE);
        hv.vb <= v_nxt >= V_W'(V_ACTIVE);
    end
end

endmodule

`default_nettype wire

//--- source/video_txt.sv
`timescale 1ns/1ns
`default_nettype none

module video_txt import video_pkg::*, host_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    input  cpu_wr_t    cpu,
    input  prom_wr_t   prom,
    input  hv_t        hv,
    output layer_pix_t pix
);

logic [TILE_IDX_W-1:0] tile_idx;
logic                  map_we;
txt_tile_t             tile_q;       // Stage 1
logic [TILE_SZ_W-1:0]  row_s1;
logic [TILE_SZ_W-1:0]  col_s1;
logic [7:0]            glyph_q;      // Stage 2
logic [TILE_SZ_W-1:0]  col_s2;
logic [3:0]            color_s2;
logic [PIX_LAG-1:0]    hb_d;
logic [PIX_LAG-1:0]    vb_d;
logic                  blank;

assign map_we   = cpu.we && cpu.addr[7:MAP_AW] == TXT_BASE[7:MAP_AW];
// Row major, index = row * TILE_COLS + column
assign tile_idx = {hv.v[TILE_SZ_W +: TILE_ROW_W], hv.h[TILE_SZ_W +: TILE_COL_W]};

video_ram #(
    .elem_t ( txt_tile_t ),
    .DEPTH  ( TILE_CNT   )
) u_map (
    .clk    ( clk                   ),
    .we     ( map_we                ),
    .waddr  ( cpu.addr[MAP_AW-1:0]  ),
    .wdata  ( txt_tile_t'(cpu.data) ),
    .ren    ( pxl_cen               ),
    .raddr  ( tile_idx              ),
    .rdata  ( tile_q                )
);

// Character generator, addressed by code * 8 + row
video_ram #(
    .elem_t ( logic [7:0] ),
    .DEPTH  ( GLYPH_DEPTH )
) u_glyph (
    .clk    ( clk                  ),
    .we     ( prom.glyph_we        ),
    .waddr  ( prom.addr[6:0]       ),
    .wdata  ( prom.data            ),
    .ren    ( pxl_cen              ),
    .raddr  ( {tile_q.code, row_s1} ),
    .rdata  ( glyph_q              )
);

always_ff @(posedge clk) begin
    if (pxl_cen) begin
        row_s1   <= hv.v[TILE_SZ_W-1:0];
        col_s1   <= hv.h[TILE_SZ_W-1:0];
        col_s2   <= col_s1;
        color_s2 <= tile_q.color;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        hb_d <= '0;
        vb_d <= '0;
    end else if (pxl_cen) begin
        hb_d <= PIX_LAG'({hb_d, hv.hb});
        vb_d <= PIX_LAG'({vb_d, hv.vb});
    end
end

assign blank = hb_d[PIX_LAG-1] | vb_d[PIX_LAG-1];

always_comb begin
    pix.color = color_s2;
    pix.valid = glyph_q[3'd7 - col_s2] & ~blank;   // Bit 7 is the leftmost pixel
    pix.hb    = hb_d[PIX_LAG-1];
    pix.vb    = vb_d[PIX_LAG-1];
end

endmodule

`default_nettype wire

//--- verif/video_chk.sv
`timescale 1ns/1ns
`default_nettype none

module video_chk import video_pkg::*; (
    input logic clk,
    input logic rst,
    input logic pxl_cen,
    input rgb_t rgb,
    input logic HB,
    input logic VB
);

int fail_cnt = 0;      // Failed assertion count

// Blanked output is black
blank_black: assert property (@(posedge clk) disable iff (rst) (HB || VB) |-> rgb == '0)
    else begin
        fail_cnt++;
        $error("rgb not zero while HB or VB is high");
    end

blue_lsb_zero: assert property (@(posedge clk) rgb.blue[0] == 1'b0)
    else begin
        fail_cnt++;
        $error("blue LSB of rgb is set");
    end

// Outputs only move on pixel ticks
hold_off_tick: assert property (@(posedge clk) disable iff (rst)
                                !pxl_cen |=> $stable({rgb, HB, VB}))
    else begin
        fail_cnt++;
        $error("rgb, HB or VB changed without a pixel tick");
    end

reset_low: assert property (@(posedge clk) $fell(rst) |-> !HB && !VB)
    else begin
        fail_cnt++;
        $error("HB or VB high right after reset");
    end

endmodule

bind video video_chk u_chk (
    .clk     ( clk     ),
    .rst     ( rst     ),
    .pxl_cen ( pxl_cen ),
    .rgb     ( rgb     ),
    .HB      ( HB      ),
    .VB      ( VB      )
);

`default_nettype wire

//--- verif/video_tb.sv
`timescale 1ns/1ns
`default_nettype none

module video_tb import video_pkg::*, host_pkg::*; ();

localparam int FRAME_CLKS = 2 * H_TOTAL * V_TOTAL;   // pxl_cen every other clk

logic     clk     = 1'b0;
logic     rst     = 1'b1;
logic     pxl_cen = 1'b0;
cpu_wr_t  cpu     = '0;
prom_wr_t prom    = '0;
rgb_t     rgb;
logic     HB;
logic     VB;

// Mirrors of everything written to the DUT
logic [7:0]  pal_mem   [PAL_DEPTH];
logic [7:0]  glyph_mem [GLYPH_DEPTH];
logic [7:0]  tile_mem  [TILE_CNT];
logic [3:0]  cell_mem  [TILE_CNT];

logic [31:0] lfsr     = 32'he58d5e7d;
int          frame_no = 1;              // Frame 1 is the loading frame
int          pix_x    = 0;
int          line_y   = 0;
int          hb_run   = 0;
logic        prev_hb  = 1'b0;
logic        prev_vb  = 1'b0;
logic        run_done = 1'b0;

video i_dut (
    .clk     ( clk     ),
    .rst     ( rst     ),
    .pxl_cen ( pxl_cen ),
    .cpu     ( cpu     ),
    .prom    ( prom    ),
    .rgb     ( rgb     ),
    .HB      ( HB      ),
    .VB      ( VB      )
);

always #50 clk = ~clk;

// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    logic       fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        v    = {v[6:0], fb};
    end
    return v;
endfunction

// Colour of screen pixel (x, y) from the mirrors
function automatic rgb_t expected_rgb(input int x, input int y);
    int         tile;
    int         pidx;
    logic [7:0] row_bits;
    logic [7:0] pal;
    rgb_t       e;
    tile     = (y / 8 % TILE_ROWS) * TILE_COLS + x / 8 % TILE_COLS;
    row_bits = glyph_mem[int'(tile_mem[tile][7:4]) * 8 + y % 8] << (x % 8);
    if (row_bits[7]) begin
        pidx = 16 + int'(tile_mem[tile][3:0]);   // Text wins
    end else begin
        pidx = int'(cell_mem[tile]);
    end
    pal     = pal_mem[pidx];
    e.red   = pal[7:5];
    e.green = pal[4:2];
    e.blue  = {pal[1:0], 1'b0};
    return e;
endfunction

task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    $display("Test failed");
    $fatal(1);
endtask

task automatic prom_write(input logic [7:0] addr, input logic [7:0] data,
                          input logic glyph_we, input logic pal_we);
    @(negedge clk);
    prom.addr     <= addr;
    prom.data     <= data;
    prom.glyph_we <= glyph_we;
    prom.pal_we   <= pal_we;
endtask

task automatic cpu_write(input logic [7:0] addr, input logic [7:0] data, input logic we);
    @(negedge clk);
    cpu.addr <= addr;
    cpu.data <= data;
    cpu.we   <= we;
endtask

// Checks one output tick and counts positions from HB and VB
task automatic sample_tick();
    rgb_t exp_rgb;
    assert (!(HB || VB) || rgb == '0) else value_error("rgb while blanked", 32'(rgb), 32'h0);
    assert (rgb.blue[0] == 1'b0) else value_error("rgb.blue[0]", 32'(rgb.blue[0]), 32'h0);
    if (VB && !prev_vb && frame_no >= 2) begin
        assert (line_y == V_ACTIVE) else value_error("unblanked lines", line_y, V_ACTIVE);
        if (frame_no == 3) begin
            run_done = 1'b1;
        end
    end
    if (!VB && prev_vb) begin
        frame_no++;
        pix_x  = 0;
        line_y = 0;
    end
    if (HB) begin
        hb_run++;
    end
    if (!HB && prev_hb) begin
        if (frame_no >= 2) begin
            assert (hb_run == H_TOTAL - H_ACTIVE)
                else value_error("HB ticks per line", hb_run, H_TOTAL - H_ACTIVE);
        end
        hb_run = 0;
    end
    if (HB && !prev_hb && !VB) begin
        if (frame_no >= 2) begin
            assert (pix_x == H_ACTIVE) else value_error("unblanked ticks", pix_x, H_ACTIVE);
        end
        pix_x = 0;
        line_y++;
    end
    if (!HB && !VB && frame_no >= 2) begin
        exp_rgb = expected_rgb(pix_x, line_y);
        assert (rgb == exp_rgb)
            else value_error($sformatf("rgb at x=%0d y=%0d", pix_x, line_y),
                             32'(rgb), 32'(exp_rgb));
        pix_x++;
    end
    prev_hb = HB;
    prev_vb = VB;
endtask

// Sample half a clock after each pixel tick
always @(negedge clk) begin
    if (pxl_cen && !rst) begin
        sample_tick();
    end
    pxl_cen <= ~pxl_cen;
end

always @(posedge clk) begin
    if (i_dut.u_chk.fail_cnt != 0) begin
        $display("Test failed");
        $fatal(1);
    end
end

initial begin
    logic [7:0] d;
    repeat (8) @(negedge clk);
    rst <= 1'b0;
    assert (!HB && !VB) else value_error("{HB,VB} after reset", 32'({HB, VB}), 32'h0);

    for (int i = 0; i < PAL_DEPTH; i++) begin
        d          = take_bits(8);
        pal_mem[i] = d;
        prom_write(8'(i), d, 1'b0, 1'b1);
    end
    for (int i = 0; i < GLYPH_DEPTH; i++) begin
        d            = take_bits(8);
        glyph_mem[i] = d;
        prom_write(8'(i), d, 1'b1, 1'b0);
    end
    prom_write(8'h00, 8'h00, 1'b0, 1'b0);
    for (int i = 0; i < TILE_CNT; i++) begin
        d           = take_bits(8);
        tile_mem[i] = d;
        cpu_write(TXT_BASE + 8'(i), d, 1'b1);
    end
    for (int i = 0; i < TILE_CNT; i++) begin
        d           = take_bits(8);
        cell_mem[i] = d[3:0];    // High nibble is dropped
        cpu_write(BCK_BASE + 8'(i), d, 1'b1);
    end
    cpu_write(8'h00, 8'h00, 1'b0);

    // Vertical blanking of frame 2
    while (!(frame_no == 2 && prev_vb)) begin
        @(posedge clk);
    end
    d = take_bits(8);
    if (d == tile_mem[5]) begin
        d = ~d;
    end
    tile_mem[5] = d;
    cpu_write(TXT_BASE + 8'd5, d, 1'b1);
    cpu_write(8'h08, take_bits(8), 1'b1);    // Outside both ranges
    cpu_write(8'h1f, take_bits(8), 1'b1);
    cpu_write(8'hf3, take_bits(8), 1'b1);
    cpu_write(8'h00, 8'h00, 1'b0);

    wait (run_done);
    @(negedge clk);
    if (i_dut.u_chk.fail_cnt == 0) begin
        $display("Test passed");
        $finish;
    end else begin
        $display("Test failed");
        $fatal(1);
    end
end

// Watchdog allows four frames after reset
initial begin
    repeat (8 + 4 * FRAME_CLKS) @(posedge clk);
    $display("Timeout: frame 3 did not finish within four frames of clocks");
    $display("Test failed");
    $fatal(1);
end

endmodule

`default_nettype wire

//--- video.f
source/video_pkg.sv
source/host_pkg.sv
source/video_ram.sv
source/video_timing.sv
source/video_txt.sv
source/video_bck.sv
source/video_colmix.sv
source/video.sv
verif/video_chk.sv
verif/video_tb.sv
